//--- logic/datapath.sv
`timescale 1ns/1ns

module datapath import lc3b_types::*; (
	input logic clk,
	input logic reset_i,
	input logic pmem_ack_i,
	input lc3b_word pmem_rdata_i,
	output logic pmem_req_o,
	output logic pmem_we_o,
	output lc3b_word pmem_addr_o,
	output lc3b_word pmem_wdata_o
);

MEM_REQ inst_req;
MEM_REQ data_req;
logic inst_done;
logic data_done;
lc3b_word inst_rdata;
lc3b_word data_rdata;
logic redirect;
lc3b_word target;
logic hold;
logic stall;
lc3b_nzp nzp;
IF_ID if_id;
ID_EX id_ex;
EX_MEM ex_mem;
WB_REQ wb;

// ##############################
// pipeline stages
fetch i_fetch (
	.clk, .reset_i,
	.inst_done_i(inst_done), .inst_rdata_i(inst_rdata),
	.redirect_i(redirect), .target_i(target),
	.hold_i(hold | stall),                          // decode stall also holds if_id
	.inst_req_o(inst_req), .if_id_o(if_id)
);

decode i_decode (
	.clk, .reset_i,
	.if_id_i(if_id), .wb_i(wb),
	.flush_i(redirect), .hold_i(hold),
	.stall_o(stall), .id_ex_o(id_ex)
);

execute i_execute (
	.clk, .reset_i,
	.id_ex_i(id_ex), .nzp_i(nzp), .hold_i(hold),
	.redirect_o(redirect), .target_o(target), .ex_mem_o(ex_mem)
);

mem_stage i_mem_stage (
	.clk, .reset_i,
	.ex_mem_i(ex_mem), .data_done_i(data_done), .data_rdata_i(data_rdata),
	.data_req_o(data_req), .hold_o(hold), .wb_o(wb), .nzp_o(nzp)
);

// ##############################
// memory port
mem_arbiter i_mem_arbiter (
	.clk, .reset_i,
	.inst_req_i(inst_req), .data_req_i(data_req),
	.pmem_ack_i, .pmem_rdata_i,
	.inst_done_o(inst_done), .data_done_o(data_done),
	.inst_rdata_o(inst_rdata), .data_rdata_o(data_rdata),
	.pmem_req_o, .pmem_we_o, .pmem_addr_o, .pmem_wdata_o
);

endmodule

//--- logic/decode.sv
`timescale 1ns/1ns
`include "lc3b_macros.svh"

module decode import lc3b_types::*; (
	input logic clk,
	input logic reset_i,
	input IF_ID if_id_i,
	input WB_REQ wb_i,
	input logic flush_i,
	input logic hold_i,
	output logic stall_o,
	output ID_EX id_ex_o
);

lc3b_word regs [`LC3B_NUM_REGS];
logic [`LC3B_NUM_REGS-1:0] busy;
logic [`LC3B_NUM_REGS-1:0] busy_eff;
lc3b_opcode opcode;
lc3b_reg dr;
lc3b_reg sr1;
lc3b_reg sr2;
lc3b_word imm5;
lc3b_word off6;
lc3b_word off9;
logic use_sr1;
logic use_sr2;
logic use_dr;
logic issue;
ID_EX dec;

// write-back in the same cycle is visible to the read
function automatic lc3b_word rd_reg(input lc3b_reg r);
	if (wb_i.we && wb_i.dest == r)
		return wb_i.data;
	return regs[r];
endfunction

// ##############################
// field decode
assign opcode = if_id_i.inst[15:12];
assign dr = if_id_i.inst[11:9];
assign sr1 = if_id_i.inst[8:6];
assign sr2 = if_id_i.inst[2:0];
assign imm5 = {{11{if_id_i.inst[4]}}, if_id_i.inst[4:0]};
assign off6 = {{9{if_id_i.inst[5]}}, if_id_i.inst[5:0], 1'b0};
assign off9 = {{6{if_id_i.inst[8]}}, if_id_i.inst[8:0], 1'b0};

always_comb begin
	dec = '0;
	dec.alu_op = alu_pass;
	dec.opcode = opcode;
	dec.pc = if_id_i.pc;
	dec.dest = dr;
	dec.a = rd_reg(sr1);
	dec.sdata = rd_reg(dr);   // str source sits in the dr field
	use_sr1 = 1'b0;
	use_sr2 = 1'b0;
	use_dr = 1'b0;
	case (opcode)
		`LC3B_OP_ADD, `LC3B_OP_AND: begin
			dec.alu_op = (opcode == `LC3B_OP_ADD) ? alu_add : alu_and;
			dec.b = if_id_i.inst[5] ? imm5 : rd_reg(sr2);
			dec.regwrite = 1'b1;
			use_sr1 = 1'b1;
			use_sr2 = ~if_id_i.inst[5];
		end
		`LC3B_OP_NOT: begin
			dec.alu_op = alu_not;
			dec.regwrite = 1'b1;
			use_sr1 = 1'b1;
		end
		`LC3B_OP_LDR: begin
			dec.b = off6;
			dec.load = 1'b1;
			dec.regwrite = 1'b1;
			use_sr1 = 1'b1;
		end
		`LC3B_OP_STR: begin
			dec.b = off6;
			dec.store = 1'b1;
			use_sr1 = 1'b1;
			use_dr = 1'b1;
		end
		`LC3B_OP_BR: begin
			dec.b = off9;
			dec.branch = 1'b1;
			dec.nzp = dr;
		end
		default: ;
	endcase
end

// ##############################
// scoreboard and hazard stall
always_comb begin
	for (int r = 0; r < `LC3B_NUM_REGS; r++)
		busy_eff[r] = busy[r] & ~(wb_i.we && wb_i.dest == lc3b_reg'(r));
end

// dest is checked too so a reader never sees an older writer's value
assign stall_o = if_id_i.valid & ((use_sr1 & busy_eff[sr1]) | (use_sr2 & busy_eff[sr2])
	| ((use_dr | dec.regwrite) & busy_eff[dr]));
assign issue = if_id_i.valid & ~stall_o & ~flush_i & ~hold_i;

always_ff @(posedge clk) begin
	if (reset_i) begin
		busy <= '0;
		for (int r = 0; r < `LC3B_NUM_REGS; r++)
			regs[r] <= '0;
	end else begin
		if (wb_i.we) begin
			regs[wb_i.dest] <= wb_i.data;
			busy[wb_i.dest] <= 1'b0;
		end
		if (issue && dec.regwrite)
			busy[dr] <= 1'b1;   // set wins over a same-cycle clear
	end
end

always_ff @(posedge clk) begin
	if (reset_i) begin
		id_ex_o.valid <= 1'b0;
	end else if (!hold_i) begin
		id_ex_o <= dec;
		id_ex_o.valid <= issue;
	end
end

endmodule

//--- logic/execute.sv
`timescale 1ns/1ns
`include "lc3b_macros.svh"

module execute import lc3b_types::*; (
	input logic clk,
	input logic reset_i,
	input ID_EX id_ex_i,
	input lc3b_nzp nzp_i,
	input logic hold_i,
	output logic redirect_o,
	output lc3b_word target_o,
	output EX_MEM ex_mem_o
);

lc3b_word alu_out;
lc3b_word addr_base;
lc3b_word addr_sum;
logic mem_op;
logic taken;

// ##############################
// alu
always_comb begin
	case (id_ex_i.alu_op)
		alu_add: alu_out = id_ex_i.a + id_ex_i.b;
		alu_and: alu_out = id_ex_i.a & id_ex_i.b;
		alu_not: alu_out = ~id_ex_i.a;
		default: alu_out = id_ex_i.b;   // pass
	endcase
end

// ##############################
// address adder, shared by branch target and ldr/str
assign addr_base = id_ex_i.branch ? id_ex_i.pc + 16'd2 : id_ex_i.a;
assign addr_sum = addr_base + id_ex_i.b;
assign mem_op = (id_ex_i.opcode == `LC3B_OP_LDR) || (id_ex_i.opcode == `LC3B_OP_STR);

// branch resolves here, the two younger slots get flushed
assign taken = id_ex_i.valid & id_ex_i.branch & |(id_ex_i.nzp & nzp_i);
assign redirect_o = taken & ~hold_i;
assign target_o = addr_sum;

always_ff @(posedge clk) begin
	if (reset_i) begin
		ex_mem_o.valid <= 1'b0;
	end else if (!hold_i) begin
		ex_mem_o.result <= mem_op ? addr_sum : alu_out;
		ex_mem_o.sdata <= id_ex_i.sdata;
		ex_mem_o.dest <= id_ex_i.dest;
		ex_mem_o.load <= id_ex_i.load;
		ex_mem_o.store <= id_ex_i.store;
		ex_mem_o.regwrite <= id_ex_i.regwrite;
		ex_mem_o.valid <= id_ex_i.valid & ~id_ex_i.branch;   // branch leaves a bubble
	end
end

endmodule

//--- logic/fetch.sv
`timescale 1ns/1ns
`include "lc3b_macros.svh"

module fetch import lc3b_types::*; (
	input logic clk,
	input logic reset_i,
	input logic inst_done_i,
	input lc3b_word inst_rdata_i,
	input logic redirect_i,
	input lc3b_word target_i,
	input logic hold_i,
	output MEM_REQ inst_req_o,
	output IF_ID if_id_o
);

lc3b_word pc;
IF_ID pend;           // fetched word parked while if_id is held
logic discard;        // next done belongs to a dropped request
logic got;

assign got = inst_done_i & ~discard & ~redirect_i;

// one request at a time, none while a word is parked
assign inst_req_o = '{req: ~pend.valid, we: 1'b0, addr: pc, wdata: '0};

always_ff @(posedge clk) begin
	if (reset_i) begin
		pc <= `LC3B_RESET_PC;
		discard <= 1'b0;
		pend.valid <= 1'b0;
		if_id_o.valid <= 1'b0;
	end else if (redirect_i) begin
		pc <= target_i;
		discard <= inst_req_o.req & ~inst_done_i;   // may already be granted
		pend.valid <= 1'b0;
		if_id_o <= '{inst: `LC3B_NOP, pc: target_i, valid: 1'b0};
	end else begin
		if (inst_done_i)
			discard <= 1'b0;
		if (got)
			pc <= pc + 16'd2;
		if (!hold_i) begin
			if (pend.valid) begin
				if_id_o <= pend;
				pend.valid <= 1'b0;
			end else begin
				// no word this cycle means a bubble
				if_id_o <= '{inst: got ? inst_rdata_i : `LC3B_NOP, pc: pc, valid: got};
			end
		end else if (got) begin
			pend <= '{inst: inst_rdata_i, pc: pc, valid: 1'b1};
		end
	end
end

endmodule

//--- logic/lc3b_macros.svh
`ifndef LC3B_MACROS_SVH
`define LC3B_MACROS_SVH

// ##############################
// widths and reset values
`define LC3B_WORD_W    16
`define LC3B_REG_W     3
`define LC3B_NUM_REGS  8

`define LC3B_RESET_PC  16'h0000
`define LC3B_NZP_RESET 3'b010       // z after reset
`define LC3B_NOP       16'h0000     // br with nzp=000, never taken

// ##############################
// opcodes
`define LC3B_OP_BR     4'b0000
`define LC3B_OP_ADD    4'b0001
`define LC3B_OP_AND    4'b0101
`define LC3B_OP_LDR    4'b0110
`define LC3B_OP_STR    4'b0111
`define LC3B_OP_NOT    4'b1001

`endif

//--- logic/lc3b_types.sv
`include "lc3b_macros.svh"

package lc3b_types;

typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
typedef logic [`LC3B_REG_W-1:0] lc3b_reg;
typedef logic [2:0] lc3b_nzp;
typedef logic [3:0] lc3b_opcode;

typedef enum logic [1:0] {
	alu_pass,
	alu_add,
	alu_and,
	alu_not
} alu_op_e;

typedef enum logic [1:0] {
	arb_idle,
	arb_inst,
	arb_data,
	arb_release       // waiting for ack to drop
} arb_state_e;

typedef struct packed {
	lc3b_word inst;
	lc3b_word pc;
	logic valid;
} IF_ID;

typedef struct packed {
	lc3b_opcode opcode;
	alu_op_e alu_op;
	lc3b_word a;
	lc3b_word b;      // register operand, imm5 or shifted offset
	lc3b_word sdata;
	lc3b_reg dest;
	logic load;
	logic store;
	logic branch;
	logic regwrite;
	lc3b_nzp nzp;     // branch mask
	lc3b_word pc;
	logic valid;
} ID_EX;

typedef struct packed {
	lc3b_word result; // alu value or data address
	lc3b_word sdata;
	lc3b_reg dest;
	logic load;
	logic store;
	logic regwrite;
	logic valid;
} EX_MEM;

typedef struct packed {
	logic we;
	lc3b_reg dest;
	lc3b_word data;
} WB_REQ;

typedef struct packed {
	logic req;
	logic we;
	lc3b_word addr;
	lc3b_word wdata;
} MEM_REQ;

endpackage

//--- logic/mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter import lc3b_types::*; (
	input logic clk,
	input logic reset_i,
	input MEM_REQ inst_req_i,
	input MEM_REQ data_req_i,
	input logic pmem_ack_i,
	input lc3b_word pmem_rdata_i,
	output logic inst_done_o,
	output logic data_done_o,
	output lc3b_word inst_rdata_o,
	output lc3b_word data_rdata_o,
	output logic pmem_req_o,
	output logic pmem_we_o,
	output lc3b_word pmem_addr_o,
	output lc3b_word pmem_wdata_o
);

arb_state_e state;
arb_state_e state_n;
logic port_free;
logic grant_d;
logic grant_i;
logic ack_seen;

// new request only after the last ack has dropped
assign port_free = (state == arb_idle || state == arb_release) && !pmem_ack_i;
assign grant_d = port_free & data_req_i.req;    // older instruction first
assign grant_i = port_free & ~data_req_i.req & inst_req_i.req;

assign inst_done_o = (state == arb_inst) & pmem_ack_i;
assign data_done_o = (state == arb_data) & pmem_ack_i;
assign ack_seen = inst_done_o | data_done_o;
assign inst_rdata_o = pmem_rdata_i;
assign data_rdata_o = pmem_rdata_i;

always_comb begin
	state_n = state;
	if (grant_d)
		state_n = arb_data;
	else if (grant_i)
		state_n = arb_inst;
	else if (ack_seen)
		state_n = arb_release;
	else if (port_free)
		state_n = arb_idle;
end

always_ff @(posedge clk) begin
	if (reset_i) begin
		state <= arb_idle;
		pmem_req_o <= 1'b0;
		pmem_we_o <= 1'b0;
	end else begin
		state <= state_n;
		if (grant_d || grant_i) begin
			pmem_req_o <= 1'b1;
			pmem_we_o <= grant_d & data_req_i.we;
		end else if (ack_seen) begin
			pmem_req_o <= 1'b0;
			pmem_we_o <= 1'b0;
		end
	end
end

// address and data held stable for the whole request
always_ff @(posedge clk) begin
	if (grant_d) begin
		pmem_addr_o <= data_req_i.addr;
		pmem_wdata_o <= data_req_i.wdata;
	end else if (grant_i) begin
		pmem_addr_o <= inst_req_i.addr;
		pmem_wdata_o <= inst_req_i.wdata;
	end
end

endmodule

//--- logic/mem_stage.sv
`timescale 1ns/1ns
`include "lc3b_macros.svh"

module mem_stage import lc3b_types::*; (
	input logic clk,
	input logic reset_i,
	input EX_MEM ex_mem_i,
	input logic data_done_i,
	input lc3b_word data_rdata_i,
	output MEM_REQ data_req_o,
	output logic hold_o,
	output WB_REQ wb_o,
	output lc3b_nzp nzp_o
);

logic mem_op;
lc3b_nzp nzp_q;
lc3b_nzp nzp_new;

// ##############################
// data access
assign mem_op = ex_mem_i.valid & (ex_mem_i.load | ex_mem_i.store);

assign data_req_o.req = mem_op;
assign data_req_o.we = ex_mem_i.valid & ex_mem_i.store;
assign data_req_o.addr = ex_mem_i.result;
assign data_req_o.wdata = ex_mem_i.sdata;

// whole pipe waits on the access, released in the done cycle
assign hold_o = mem_op & ~data_done_i;

// ##############################
// write-back
assign wb_o.we = ex_mem_i.valid & ex_mem_i.regwrite & (~ex_mem_i.load | data_done_i);
assign wb_o.dest = ex_mem_i.dest;
assign wb_o.data = ex_mem_i.load ? data_rdata_i : ex_mem_i.result;

always_comb begin
	if (wb_o.data[15])
		nzp_new = 3'b100;
	else if (wb_o.data == '0)
		nzp_new = 3'b010;
	else
		nzp_new = 3'b001;
end

always_ff @(posedge clk) begin
	if (reset_i)
		nzp_q <= `LC3B_NZP_RESET;
	else if (wb_o.we)
		nzp_q <= nzp_new;
end

// a branch in execute needs the codes of the instruction just ahead of it
assign nzp_o = wb_o.we ? nzp_new : nzp_q;

endmodule

//--- verif/datapath_assertions.sv
`timescale 1ns/1ns

module datapath_assertions import lc3b_types::*; (
	input logic clk,
	input logic reset_i,
	input logic pmem_req_o,
	input logic pmem_we_o,
	input logic pmem_ack_i,
	input lc3b_word pmem_addr_o,
	input lc3b_word pmem_wdata_o
);

// ##############################
// four-phase handshake on the memory port
req_until_ack: assert property (@(posedge clk) disable iff (reset_i)
	pmem_req_o && !pmem_ack_i |=> pmem_req_o)
	else $error("pmem_req_o dropped before pmem_ack_i was seen");

no_rise_on_ack: assert property (@(posedge clk) disable iff (reset_i)
	!pmem_req_o && pmem_ack_i |=> !pmem_req_o)
	else $error("pmem_req_o rose while pmem_ack_i was still high");

stable_request: assert property (@(posedge clk) disable iff (reset_i)
	pmem_req_o && $past(pmem_req_o)
	|-> $stable(pmem_addr_o) && $stable(pmem_we_o) && $stable(pmem_wdata_o))
	else $error("address, write flag or data changed while pmem_req_o was high");

quiet_in_reset: assert property (@(posedge clk) reset_i |=> !pmem_req_o)
	else $error("pmem_req_o high during reset");

endmodule

bind mem_arbiter datapath_assertions i_assertions (.*);

//--- verif/datapath_tb.sv
`timescale 1ns/1ns
`include "lc3b_macros.svh"

module datapath_tb import lc3b_types::*; ();

localparam int NUM_PROGS = 20;
localparam int PROG_LEN = 28;
localparam int HALT_IDX = PROG_LEN - 1;
localparam lc3b_word HALT_ADDR = 16'(2 * HALT_IDX);
localparam lc3b_word FETCH_LIMIT = 16'(2 * PROG_LEN + 8);   // room for prefetch past the halt
localparam lc3b_word DATA_BASE = 16'h4000;
localparam int HALT_FETCHES = 8;
localparam int MAX_CYCLES = NUM_PROGS * PROG_LEN * 40;

logic clk;
logic reset_i;
logic pmem_ack_i;
lc3b_word pmem_rdata_i;
logic pmem_req_o;
logic pmem_we_o;
lc3b_word pmem_addr_o;
lc3b_word pmem_wdata_o;

lc3b_word mem [0:32767];   // word array indexed by byte address bits 15:1
lc3b_word prog [0:PROG_LEN-1];
logic [31:0] lfsr;
lc3b_word exp_addr [$];
lc3b_word exp_data [$];
string exp_tag [$];
lc3b_word load_addr [$];
int store_ptr;
int load_ptr;
int halt_seen;
int cur_prog;
int errors;
int checks;
int cycles;
logic pending;
logic [1:0] delay;

datapath i_dut (.*);

initial clk = 1'b0;
always #20 clk = ~clk;

function automatic lc3b_word take_bits(input int n);
	lc3b_word v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
		v = {v[14:0], lfsr[0]};
	end
	return v;
endfunction

function automatic lc3b_word fill_word(input lc3b_word a, input int p);
	return (a * 16'h9e37) ^ 16'h3c5a ^ lc3b_word'(p * 257);
endfunction

// ##############################
// program generator
task automatic build_program(input int p);
	logic [2:0] kind;
	lc3b_reg dr;
	lc3b_reg sr;
	lc3b_word r;
	int off;
	prog[0] = {`LC3B_OP_LDR, 3'd6, 3'd6, 6'd31};   // r6 <- data base at byte 62
	for (int i = 1; i < HALT_IDX; i++) begin
		kind = 3'(take_bits(3));
		dr = 3'(take_bits(3));
		if (dr == 3'd6)
			dr = 3'd7;
		sr = 3'(take_bits(3));
		case (kind)
			3'd0, 3'd1, 3'd2: begin
				r = take_bits(6);
				prog[i] = {(kind == 3'd2) ? `LC3B_OP_AND : `LC3B_OP_ADD, dr, sr,
					r[5], r[5] ? r[4:0] : {2'b00, r[2:0]}};
			end
			3'd3: prog[i] = {`LC3B_OP_NOT, dr, sr, 6'b111111};
			3'd4: begin
				r = take_bits(5);
				prog[i] = {`LC3B_OP_LDR, dr, 3'd6, 1'b0, r[4:0]};
			end
			3'd5, 3'd6: begin
				r = take_bits(5);
				prog[i] = {`LC3B_OP_STR, sr, 3'd6, 1'b0, r[4:0]};   // sr is the stored reg
			end
			default: begin
				r = take_bits(3);
				off = r % (HALT_IDX - i);   // forward only and never past the halt
				prog[i] = {`LC3B_OP_BR, sr, 9'(off)};
			end
		endcase
	end
	prog[HALT_IDX] = {`LC3B_OP_BR, 3'b111, 9'h1ff};
	for (int w = 0; w < 32; w++)
		mem[w] = (w < PROG_LEN) ? prog[w] : `LC3B_NOP;
	mem[31] = DATA_BASE;
	for (int k = 0; k < 32; k++)
		mem[(DATA_BASE >> 1) + k] = fill_word(DATA_BASE + lc3b_word'(2 * k), p);
endtask

// ##############################
// ISA model
task automatic run_model(input int p);
	lc3b_word regs [8];
	lc3b_word dmem [32];
	int wr_at [8];
	lc3b_nzp nzp;
	lc3b_word inst;
	lc3b_word val;
	lc3b_word a;
	lc3b_word b;
	logic writes;
	logic taken_seen;
	int pc;
	int step;
	exp_addr.delete();
	exp_data.delete();
	exp_tag.delete();
	load_addr.delete();
	for (int r = 0; r < 8; r++) begin
		regs[r] = '0;
		wr_at[r] = -10;
	end
	for (int k = 0; k < 32; k++)
		dmem[k] = fill_word(DATA_BASE + lc3b_word'(2 * k), p);
	nzp = 3'b010;   // codes start as z
	pc = 0;
	step = 0;
	taken_seen = 1'b0;
	while (pc != HALT_IDX) begin
		inst = prog[pc];
		writes = 1'b1;
		a = regs[inst[8:6]] + {{9{inst[5]}}, inst[5:0], 1'b0};
		b = inst[5] ? {{11{inst[4]}}, inst[4:0]} : regs[inst[2:0]];
		val = '0;
		pc++;
		case (inst[15:12])
			`LC3B_OP_ADD: val = regs[inst[8:6]] + b;
			`LC3B_OP_AND: val = regs[inst[8:6]] & b;
			`LC3B_OP_NOT: val = ~regs[inst[8:6]];
			`LC3B_OP_LDR: begin
				load_addr.push_back(a);
				val = (a == 16'd62) ? DATA_BASE : dmem[a[5:1]];
			end
			`LC3B_OP_STR: begin
				writes = 1'b0;
				exp_addr.push_back(a);
				exp_data.push_back(regs[inst[11:9]]);
				if (step - wr_at[inst[11:9]] <= 2 || step - wr_at[6] <= 2)
					exp_tag.push_back("hazard");
				else if (taken_seen)
					exp_tag.push_back("branch");
				else
					exp_tag.push_back("store");
				dmem[a[5:1]] = regs[inst[11:9]];
			end
			default: begin
				writes = 1'b0;
				if (|(inst[11:9] & nzp)) begin
					pc = pc + int'(inst[8:0]);
					taken_seen = 1'b1;
				end
			end
		endcase
		if (writes) begin
			regs[inst[11:9]] = val;
			wr_at[inst[11:9]] = step;
			nzp = val[15] ? 3'b100 : ((val == '0) ? 3'b010 : 3'b001);
		end
		step++;
	end
endtask

// ##############################
// port checks and memory responder
task automatic check_store(input lc3b_word a, input lc3b_word d);
	checks++;
	if (store_ptr >= exp_addr.size()) begin
		errors++;
		$display("error halt: program %0d stored %h to %h after its last store", cur_prog, d, a);
	end else begin
		if (a != exp_addr[store_ptr] || d != exp_data[store_ptr]) begin
			errors++;
			$display("error %s: program %0d store %0d expected %h_%h actual %h_%h",
				exp_tag[store_ptr], cur_prog, store_ptr,
				exp_addr[store_ptr], exp_data[store_ptr], a, d);
		end
		store_ptr++;
	end
endtask

task automatic check_read(input lc3b_word a);
	lc3b_word next_ld;
	checks++;
	next_ld = (load_ptr < load_addr.size()) ? load_addr[load_ptr] : 16'hffff;
	if (load_ptr < load_addr.size() && a == next_ld) begin
		load_ptr++;
	end else if (a >= FETCH_LIMIT) begin
		errors++;
		$display("error address: program %0d expected fetch below %h or load %h actual %h",
			cur_prog, FETCH_LIMIT, next_ld, a);
	end
endtask

always @(posedge clk) begin
	#5;
	if (pmem_ack_i && !pmem_req_o) begin
		// ack lingers a random time after req drops
		if (!pending) begin
			pending = 1'b1;
			delay = 2'(take_bits(2));
		end
		if (delay == 2'd0) begin
			pending = 1'b0;
			pmem_ack_i = 1'b0;
		end else begin
			delay = delay - 2'd1;
		end
	end else if (pmem_req_o && !pmem_ack_i) begin
		if (!pending) begin
			pending = 1'b1;
			delay = 2'(take_bits(2));
		end
		if (delay == 2'd0) begin
			if (pmem_we_o) begin
				check_store(pmem_addr_o, pmem_wdata_o);
				mem[pmem_addr_o[15:1]] = pmem_wdata_o;
			end else begin
				check_read(pmem_addr_o);
				pmem_rdata_i = mem[pmem_addr_o[15:1]];
				if (pmem_addr_o == HALT_ADDR)
					halt_seen++;
			end
			pending = 1'b0;
			pmem_ack_i = 1'b1;
		end else begin
			delay = delay - 2'd1;
		end
	end else if (!pmem_req_o) begin
		pending = 1'b0;   // request withdrawn by reset
	end
end

always @(posedge clk) begin
	cycles++;
	if (cycles >= MAX_CYCLES) begin
		$display("timeout: program %0d never reached its halt loop, %0d checks, %0d errors",
			cur_prog, checks, errors);
		$display("FAIL: see errors above");
		$finish;
	end
end

// ##############################
// test sequence
task automatic run_program(input int p);
	@(posedge clk);
	#5;
	reset_i = 1'b1;
	repeat (5) @(posedge clk);
	#5;
	cur_prog = p;
	build_program(p);
	run_model(p);
	store_ptr = 0;
	load_ptr = 0;
	halt_seen = 0;
	reset_i = 1'b0;
	while (halt_seen < HALT_FETCHES)
		@(posedge clk);
	checks++;
	if (store_ptr != exp_addr.size() || load_ptr != load_addr.size()) begin
		errors++;
		$display("error halt: program %0d expected %0d stores %0d loads actual %0d stores %0d loads",
			p, exp_addr.size(), load_addr.size(), store_ptr, load_ptr);
	end
endtask

initial begin
	reset_i = 1'b1;
	pmem_ack_i = 1'b0;
	pmem_rdata_i = '0;
	lfsr = 32'h8624;
	errors = 0;
	checks = 0;
	cycles = 0;
	cur_prog = 0;
	pending = 1'b0;
	delay = 2'd0;
	halt_seen = 0;
	store_ptr = 0;
	load_ptr = 0;
	for (int w = 0; w < 32768; w++)
		mem[w] = fill_word(lc3b_word'(w << 1), 0);
	for (int p = 0; p < NUM_PROGS; p++)
		run_program(p);
	$display("%0d programs, %0d checks, %0d errors", NUM_PROGS, checks, errors);
	if (errors == 0)
		$display("PASS: all tests");
	else
		$display("FAIL: see errors above");
	$finish;
end

endmodule

//--- vlog.f
+incdir+logic
logic/lc3b_types.sv
logic/fetch.sv
logic/decode.sv
logic/execute.sv
logic/mem_stage.sv
logic/mem_arbiter.sv
logic/datapath.sv
verif/datapath_assertions.sv
verif/datapath_tb.sv
